// File: include/aib_chan_defines.svh
// AIB microbump channel sizing
// bump count, spare count and the lane and pair widths derived from them
// the bump count must be even and at least 6

`ifndef AIB_CHAN_DEFINES_SVH
`define AIB_CHAN_DEFINES_SVH

// ------------------------------------------------------------
// channel geometry
// ------------------------------------------------------------

// physical bumps in the channel, spares included
`define AIB_NBMP 16

// spare bumps, one pair at the top positions
`define AIB_NSPR 2

// logical data lanes carried by the channel
`define AIB_NDAT (`AIB_NBMP - `AIB_NSPR)

// logical pairs, also the engage vector width
`define AIB_NPAIR (`AIB_NDAT / 2)

`endif

// File: hdl/aib_chan_pkg.sv
// AIB channel shared types
// vector types sized from the channel defines and the scan control bundle

`default_nettype none

`include "aib_chan_defines.svh"

package aib_chan_pkg;

  // ------------------------------------------------------------
  // vectors
  // ------------------------------------------------------------

  // one bit per physical bump
  typedef logic [`AIB_NBMP-1:0] bump_vec_t;

  // one bit per logical data lane
  typedef logic [`AIB_NDAT-1:0] data_vec_t;

  // one redundancy engage bit per logical pair
  typedef logic [`AIB_NPAIR-1:0] engage_vec_t;

  // one bit per physical pair, spare pair on top
  typedef logic [`AIB_NPAIR:0] pair_vec_t;

  // ------------------------------------------------------------
  // boundary scan control
  // ------------------------------------------------------------
  typedef struct packed {
    logic mode;     // scan register drives the bumps
    logic scan_en;  // shift chain by one
    logic capture;  // parallel load of bump inputs
    logic scanin;   // serial input at bump 0
  } scan_ctrl_t;

endpackage

`default_nettype wire

// File: hdl/aib_redn_map.sv
// AIB pair redundancy map
// finds the lowest engaged logical pair and turns it into a one-hot
// broken-pair mask and a thermometer shift mask over the physical pairs

`timescale 1ns/1ps
`default_nettype none

`include "aib_chan_defines.svh"

module aib_redn_map (
  input  aib_chan_pkg::engage_vec_t redn_engage,
  output aib_chan_pkg::pair_vec_t   shift_pairs,
  output aib_chan_pkg::pair_vec_t   broken_pairs
);

  // ------------------------------------------------------------
  // lowest engaged pair search
  // ------------------------------------------------------------
  // pairs below the break pass straight, the break itself is
  // one-hot, everything above it moves up one pair
  always_comb begin
    logic found;
    found        = 1'b0;
    shift_pairs  = '0;
    broken_pairs = '0;
    for (int q = 0; q < `AIB_NPAIR; q++) begin
      if (found) begin
        shift_pairs[q] = 1'b1;
      end else if (redn_engage[q]) begin
        broken_pairs[q] = 1'b1;
        found           = 1'b1;
      end
    end
    // spare pair either takes the shifted top pair or idles at zero
    if (found) begin
      shift_pairs[`AIB_NPAIR] = 1'b1;
    end else begin
      broken_pairs[`AIB_NPAIR] = 1'b1;
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  // only a single broken pair can be repaired per channel,
  // the tx and rx steering both rely on the masks being one-hot
  always_comb begin
    assert ($onehot0(redn_engage))
      else $error("more than one redundancy engage bit set: %h", redn_engage);
  end

endmodule

`default_nettype wire

// File: hdl/aib_tx_lanes.sv
// AIB transmit lanes
// steers logical tx pairs onto physical bump pairs around the broken pair
// and registers the bumps, or registers the scan register in scan mode

`timescale 1ns/1ps
`default_nettype none

`include "aib_chan_defines.svh"

module aib_tx_lanes (
  input  logic                      tx_clk,
  input  logic                      reset,
  input  aib_chan_pkg::data_vec_t   tx_data,
  input  aib_chan_pkg::pair_vec_t   shift_pairs,
  input  aib_chan_pkg::pair_vec_t   broken_pairs,
  input  logic                      scan_mode,
  input  aib_chan_pkg::bump_vec_t   bsr_q,
  output aib_chan_pkg::bump_vec_t   bump_out
);

  import aib_chan_pkg::*;

  bump_vec_t steered;

  // ------------------------------------------------------------
  // per physical pair steering
  // ------------------------------------------------------------
  genvar q;
  for (q = 0; q <= `AIB_NPAIR; q++) begin : g_pair
    logic [1:0] same_pair;
    logic [1:0] below_pair;

    // spare pair has no logical pair of its own
    if (q < `AIB_NPAIR) begin : g_same
      assign same_pair = tx_data[2*q +: 2];
    end else begin : g_no_same
      assign same_pair = 2'b00;
    end

    // bottom pair is never shifted into
    if (q > 0) begin : g_below
      assign below_pair = tx_data[2*(q-1) +: 2];
    end else begin : g_no_below
      assign below_pair = 2'b00;
    end

    // broken wins, then shift, else straight through
    assign steered[2*q +: 2] = broken_pairs[q] ? 2'b00 :
                               shift_pairs[q]  ? below_pair : same_pair;
  end

  // ------------------------------------------------------------
  // bump launch register
  // ------------------------------------------------------------
  always_ff @(posedge tx_clk) begin
    if (reset) begin
      bump_out <= '0;
    end else if (scan_mode) begin
      // boundary scan drive
      bump_out <= bsr_q;
    end else begin
      bump_out <= steered;
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  // exactly one pair marked broken, and the shifted pairs are
  // all of the pairs above it and nothing else
  a_mask_sane : assert property (
    @(posedge tx_clk) disable iff (reset)
    $onehot(broken_pairs) &&
    (shift_pairs == ~(broken_pairs | pair_vec_t'(broken_pairs - 1)))
  ) else $error("bad redundancy masks, shift %h broken %h", shift_pairs, broken_pairs);

endmodule

`default_nettype wire

// File: hdl/aib_rx_lanes.sv
// AIB receive lanes
// captures the bumps with the redundancy masks of the same cycle and
// rebuilds each logical pair from the physical pair that carries it

`timescale 1ns/1ps
`default_nettype none

`include "aib_chan_defines.svh"

module aib_rx_lanes (
  input  logic                      tx_clk,
  input  logic                      reset,
  input  aib_chan_pkg::bump_vec_t   bump_in,
  input  aib_chan_pkg::pair_vec_t   shift_pairs,
  input  aib_chan_pkg::pair_vec_t   broken_pairs,
  output aib_chan_pkg::data_vec_t   rx_data
);

  import aib_chan_pkg::*;

  bump_vec_t bump_q;
  pair_vec_t shift_q;
  pair_vec_t broken_q;
  // captured bumps with the broken pair cleared
  bump_vec_t bump_clean;

  // ------------------------------------------------------------
  // capture register
  // ------------------------------------------------------------
  // masks travel with the data so the unsteer matches the capture
  always_ff @(posedge tx_clk) begin
    if (reset) begin
      bump_q   <= '0;
      shift_q  <= '0;
      broken_q <= '0;
    end else begin
      bump_q   <= bump_in;
      shift_q  <= shift_pairs;
      broken_q <= broken_pairs;
    end
  end

  // ------------------------------------------------------------
  // unsteer
  // ------------------------------------------------------------
  genvar q;
  genvar p;

  // broken pair value is dropped here
  for (q = 0; q <= `AIB_NPAIR; q++) begin : g_clean
    assign bump_clean[2*q +: 2] = broken_q[q] ? 2'b00 : bump_q[2*q +: 2];
  end

  // logical pair p sits one pair up once the pair above it is shifted
  for (p = 0; p < `AIB_NPAIR; p++) begin : g_lane
    assign rx_data[2*p +: 2] = shift_q[p+1] ? bump_clean[2*(p+1) +: 2] :
                                              bump_clean[2*p +: 2];
  end

endmodule

`default_nettype wire

// File: hdl/aib_bsr_chain.sv
// AIB boundary scan register
// one scan bit per bump, chained from bump 0 up to the top bump
// parallel capture of the bump inputs, serial shift, hold otherwise

`timescale 1ns/1ps
`default_nettype none

`include "aib_chan_defines.svh"

module aib_bsr_chain (
  input  logic                      tx_clk,
  input  logic                      reset,
  input  aib_chan_pkg::bump_vec_t   bump_in,
  input  aib_chan_pkg::scan_ctrl_t  scan_ctrl,
  output aib_chan_pkg::bump_vec_t   bsr_q,
  output logic                      scan_out
);

  // ------------------------------------------------------------
  // scan register
  // ------------------------------------------------------------
  always_ff @(posedge tx_clk) begin
    if (reset) begin
      bsr_q <= '0;
    end else if (scan_ctrl.scan_en) begin
      // shift toward the top bump, scanin enters at bump 0
      bsr_q <= {bsr_q[`AIB_NBMP-2:0], scan_ctrl.scanin};
    end else if (scan_ctrl.capture) begin
      bsr_q <= bump_in;
    end
  end

  // top bump is last in chain
  assign scan_out = bsr_q[`AIB_NBMP-1];

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  // tap sequencing outside the channel keeps capture and shift apart
  a_cap_shift_excl : assert property (
    @(posedge tx_clk) disable iff (reset)
    !(scan_ctrl.capture && scan_ctrl.scan_en)
  ) else $error("scan capture and shift strobes high together");

endmodule

`default_nettype wire

// File: hdl/aib_chan_top.sv
// AIB microbump IO channel
// transmit and receive lanes with pair redundancy and a boundary scan
// chain across all bumps, single clock domain on tx_clk

`timescale 1ns/1ps
`default_nettype none

module aib_chan_top (
  input  logic                      tx_clk,
  input  logic                      reset,
  input  aib_chan_pkg::data_vec_t   tx_data,
  output aib_chan_pkg::data_vec_t   rx_data,
  input  aib_chan_pkg::engage_vec_t redn_engage,
  output aib_chan_pkg::bump_vec_t   bump_out,
  input  aib_chan_pkg::bump_vec_t   bump_in,
  input  aib_chan_pkg::scan_ctrl_t  scan_ctrl,
  output logic                      scan_out
);

  import aib_chan_pkg::*;

  // redundancy masks shared by tx and rx
  pair_vec_t shift_pairs;
  pair_vec_t broken_pairs;
  // scan register image toward the tx launch mux
  bump_vec_t bsr_q;

  // ------------------------------------------------------------
  // redundancy decode
  // ------------------------------------------------------------
  aib_redn_map u_redn_map (
    .redn_engage  (redn_engage),
    .shift_pairs  (shift_pairs),
    .broken_pairs (broken_pairs)
  );

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------
  aib_tx_lanes u_tx_lanes (
    .tx_clk       (tx_clk),
    .reset        (reset),
    .tx_data      (tx_data),
    .shift_pairs  (shift_pairs),
    .broken_pairs (broken_pairs),
    .scan_mode    (scan_ctrl.mode),
    .bsr_q        (bsr_q),
    .bump_out     (bump_out)
  );

  aib_rx_lanes u_rx_lanes (
    .tx_clk       (tx_clk),
    .reset        (reset),
    .bump_in      (bump_in),
    .shift_pairs  (shift_pairs),
    .broken_pairs (broken_pairs),
    .rx_data      (rx_data)
  );

  // boundary scan, capture side taps the bump inputs
  aib_bsr_chain u_bsr_chain (
    .tx_clk    (tx_clk),
    .reset     (reset),
    .bump_in   (bump_in),
    .scan_ctrl (scan_ctrl),
    .bsr_q     (bsr_q),
    .scan_out  (scan_out)
  );

endmodule

`default_nettype wire

// File: test/tb_aib_chan_checks.svh
// AIB channel testbench helpers
// typed compare tasks, xorshift generator, reference steering model
// and the bounded clock edge wait used by every stimulus step

`ifndef TB_AIB_CHAN_CHECKS_SVH
`define TB_AIB_CHAN_CHECKS_SVH

// ------------------------------------------------------------
// compare tasks
// ------------------------------------------------------------
task automatic check_data(input string name, input data_vec_t got, input data_vec_t exp);
  if (!timed_out && got !== exp) begin
    value_errs++;
    $display("ERR %s: got %h expected %h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_bumps(input string name, input bump_vec_t got, input bump_vec_t exp);
  if (!timed_out && got !== exp) begin
    value_errs++;
    $display("ERR %s: got %h expected %h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (!timed_out && got !== exp) begin
    value_errs++;
    $display("ERR %s: got %h expected %h at %0t", name, got, exp, $time);
  end
endtask

// 32 bit xorshift, shifts 13 17 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// ------------------------------------------------------------
// reference steering model
// ------------------------------------------------------------
// lowest engaged pair, pair count when nothing is engaged
function automatic int lowest_engaged(input engage_vec_t eng);
  int e;
  e = `AIB_NPAIR;
  for (int p = `AIB_NPAIR - 1; p >= 0; p--) begin
    if (eng[p]) begin
      e = p;
    end
  end
  return e;
endfunction

// logical pair p sits on physical p below the break, p+1 from it upward
// broken pair and an idle spare stay zero
function automatic bump_vec_t place_model(input data_vec_t d, input engage_vec_t eng);
  bump_vec_t b;
  int        e;
  b = '0;
  e = lowest_engaged(eng);
  for (int p = 0; p < `AIB_NPAIR; p++) begin
    if (p < e) begin
      b[2*p +: 2] = d[2*p +: 2];
    end else begin
      b[2*(p+1) +: 2] = d[2*p +: 2];
    end
  end
  return b;
endfunction

function automatic data_vec_t receive_model(input bump_vec_t b, input engage_vec_t eng);
  data_vec_t d;
  int        e;
  e = lowest_engaged(eng);
  for (int p = 0; p < `AIB_NPAIR; p++) begin
    if (p < e) begin
      d[2*p +: 2] = b[2*p +: 2];
    end else begin
      d[2*p +: 2] = b[2*(p+1) +: 2];
    end
  end
  return d;
endfunction

// stuck 10 pattern on one pair, negative pair means a healthy channel
function automatic bump_vec_t inject_fault(input bump_vec_t b, input int pair);
  bump_vec_t r;
  r = b;
  if (pair >= 0) begin
    r[2*pair +: 2] = 2'b10;
  end
  return r;
endfunction

// ------------------------------------------------------------
// clock edge wait
// ------------------------------------------------------------
// polls for the next rising edge, then lands on the drive point
task automatic next_cycle();
  int target;
  int waited;
  target = edge_count + 1;
  waited = 0;
  if (!timed_out) begin
    while (edge_count < target && waited < edge_limit_ns) begin
      #1;
      waited++;
    end
    if (edge_count < target) begin
      timeout_errs++;
      timed_out = 1'b1;
      $display("timeout: no rising edge of tx_clk within %0d ns", edge_limit_ns);
    end else begin
      #(last_edge_t + drive_delay_ns - $time);
    end
  end
endtask

`endif

// File: test/tb_aib_chan.sv
// AIB channel testbench
// bump_out loops back into bump_in with an optional stuck pair,
// a table of words and engage values runs through the channel,
// then boundary scan capture, shift and drive are exercised

`timescale 1ns/1ps
`default_nettype none

`include "aib_chan_defines.svh"

module tb_aib_chan;

  import aib_chan_pkg::*;

  localparam int          clk_half_ns    = 10;
  localparam int          drive_delay_ns = 2;
  localparam int          edge_limit_ns  = 40;
  localparam logic [31:0] rng_seed       = 32'h4411_9b09;

  typedef enum logic [1:0] {kind_plain, kind_steer, kind_fix, kind_break} kind_t;

  // one table row: what to send and how the channel is set up
  typedef struct packed {
    kind_t       kind;
    engage_vec_t engage;
    int          fault;
    logic        rnd;
    data_vec_t   data;
  } entry_t;

  logic        tx_clk;
  logic        reset;
  data_vec_t   tx_data;
  data_vec_t   rx_data;
  engage_vec_t redn_engage;
  bump_vec_t   bump_out;
  bump_vec_t   bump_in;
  scan_ctrl_t  scan_ctrl;
  logic        scan_out;

  logic        loop_en;
  int          fault_pair;
  logic [31:0] rng_state;
  int          value_errs;
  int          timeout_errs;
  logic        timed_out;
  int          edge_count;
  time         last_edge_t;
  entry_t      table_q[$];

  aib_chan_top dut0 (
    .tx_clk      (tx_clk),
    .reset       (reset),
    .tx_data     (tx_data),
    .rx_data     (rx_data),
    .redn_engage (redn_engage),
    .bump_out    (bump_out),
    .bump_in     (bump_in),
    .scan_ctrl   (scan_ctrl),
    .scan_out    (scan_out)
  );

  always #(clk_half_ns) tx_clk = ~tx_clk;

  // edge bookkeeping for the bounded waits
  always @(posedge tx_clk) begin
    edge_count  = edge_count + 1;
    last_edge_t = $time;
  end

  // bump loopback with the stuck pair
  assign bump_in = loop_en ? inject_fault(bump_out, fault_pair) : '0;

  `include "tb_aib_chan_checks.svh"

  function automatic logic [31:0] draw_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic add_entry(input kind_t kind, input engage_vec_t eng, input int fault,
                           input logic rnd, input data_vec_t data);
    entry_t e;
    e.kind   = kind;
    e.engage = eng;
    e.fault  = fault;
    e.rnd    = rnd;
    e.data   = data;
    table_q.push_back(e);
  endtask

  // ------------------------------------------------------------
  // stimulus table
  // ------------------------------------------------------------
  task automatic build_table();
    engage_vec_t eng;
    int          fix_pair[3];
    fix_pair = '{0, `AIB_NPAIR / 2, `AIB_NPAIR - 1};
    for (int i = 0; i < 4; i++) begin
      add_entry(kind_plain, '0, -1, 1'b1, '0);
    end
    // every engage position on a healthy channel
    for (int q = 0; q < `AIB_NPAIR; q++) begin
      eng    = '0;
      eng[q] = 1'b1;
      add_entry(kind_steer, eng, -1, 1'b1, '0);
    end
    // stuck pair repaired at bottom, middle and top
    foreach (fix_pair[j]) begin
      eng              = '0;
      eng[fix_pair[j]] = 1'b1;
      for (int i = 0; i < 3; i++) begin
        add_entry(kind_fix, eng, fix_pair[j], 1'b1, '0);
      end
    end
    // stuck pair 1 left alone, words never carry 10 on that pair
    add_entry(kind_break, '0, 1, 1'b0, '0);
    add_entry(kind_break, '0, 1, 1'b0, '1);
    add_entry(kind_break, '0, 1, 1'b0, {(`AIB_NDAT / 2){2'b01}});
    add_entry(kind_break, '0, 1, 1'b0, '0);
    add_entry(kind_plain, '0, -1, 1'b1, '0);
    add_entry(kind_plain, '0, -1, 1'b1, '0);
  endtask

  // word sent one cycle earlier, seen through this cycle's fault and masks
  task automatic check_rx(input entry_t sent, input entry_t now);
    bump_vec_t seen;
    int        f;
    seen = inject_fault(place_model(sent.data, sent.engage), now.fault);
    f    = now.fault;
    check_data("rx_data", rx_data, receive_model(seen, now.engage));
    if (sent.engage == now.engage && sent.fault == now.fault) begin
      if (now.kind == kind_break) begin
        if (!timed_out && rx_data[2*f +: 2] === sent.data[2*f +: 2]) begin
          value_errs++;
          $display("stuck pair %0d without repair did not corrupt rx_data", f);
        end
      end else begin
        check_data("rx_data", rx_data, sent.data);
      end
    end
  endtask

  task automatic run_table();
    entry_t cur;
    entry_t prev;
    logic   have_prev;
    have_prev = 1'b0;
    foreach (table_q[i]) begin
      cur = table_q[i];
      if (cur.rnd) begin
        cur.data = data_vec_t'(draw_random());
      end
      tx_data     = cur.data;
      redn_engage = cur.engage;
      fault_pair  = cur.fault;
      next_cycle();
      check_bumps("bump_out", bump_out, place_model(cur.data, cur.engage));
      if (have_prev) begin
        check_rx(prev, cur);
      end
      prev      = cur;
      have_prev = 1'b1;
    end
    // last word still in flight, inputs held
    next_cycle();
    check_rx(prev, prev);
  endtask

  // ------------------------------------------------------------
  // boundary scan
  // ------------------------------------------------------------
  task automatic run_scan_capture();
    data_vec_t word;
    bump_vec_t cap;
    word        = data_vec_t'(draw_random());
    tx_data     = word;
    redn_engage = '0;
    fault_pair  = -1;
    next_cycle();
    cap = place_model(word, '0);
    check_bumps("bump_in", bump_in, cap);
    scan_ctrl.capture = 1'b1;
    next_cycle();
    scan_ctrl.capture = 1'b0;
    // top bump leaves first
    for (int k = 0; k < `AIB_NBMP; k++) begin
      check_bit("scan_out", scan_out, cap[`AIB_NBMP - 1 - k]);
      scan_ctrl.scan_en = 1'b1;
      scan_ctrl.scanin  = 1'b0;
      next_cycle();
    end
    scan_ctrl.scan_en = 1'b0;
    check_bit("scan_out", scan_out, 1'b0);
  endtask

  task automatic run_scan_drive();
    bump_vec_t pattern;
    pattern = bump_vec_t'(draw_random());
    for (int k = 0; k < `AIB_NBMP; k++) begin
      scan_ctrl.scan_en = 1'b1;
      scan_ctrl.scanin  = pattern[`AIB_NBMP - 1 - k];
      next_cycle();
    end
    scan_ctrl.scan_en = 1'b0;
    scan_ctrl.scanin  = 1'b0;
    scan_ctrl.mode    = 1'b1;
    tx_data           = data_vec_t'(draw_random());
    next_cycle();
    check_bumps("bump_out", bump_out, pattern);
    // tx data ignored while the chain drives
    tx_data = ~tx_data;
    next_cycle();
    check_bumps("bump_out", bump_out, pattern);
    scan_ctrl.mode = 1'b0;
    next_cycle();
    check_bumps("bump_out", bump_out, place_model(tx_data, '0));
  endtask

  task automatic report_and_finish();
    $display("errors: %0d value, %0d timeout", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  initial begin
    tx_clk       = 1'b0;
    reset        = 1'b1;
    tx_data      = '0;
    redn_engage  = '0;
    scan_ctrl    = '0;
    loop_en      = 1'b0;
    fault_pair   = -1;
    rng_state    = rng_seed;
    value_errs   = 0;
    timeout_errs = 0;
    timed_out    = 1'b0;
    edge_count   = 0;
    last_edge_t  = 0;
    repeat (4) next_cycle();
    reset = 1'b0;
    check_bumps("bump_out", bump_out, '0);
    check_data("rx_data", rx_data, '0);
    check_bit("scan_out", scan_out, 1'b0);
    loop_en = 1'b1;
    build_table();
    run_table();
    run_scan_capture();
    run_scan_drive();
    report_and_finish();
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
+incdir+test
hdl/aib_chan_pkg.sv
hdl/aib_redn_map.sv
hdl/aib_tx_lanes.sv
hdl/aib_rx_lanes.sv
hdl/aib_bsr_chain.sv
hdl/aib_chan_top.sv
test/tb_aib_chan.sv

// File: Makefile
# Verilator build, run, lint and clean for the AIB channel testbench

VERILATOR  ?= verilator
TOP        ?= tb_aib_chan
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Done: errors found
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh test/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
